// File: filelist.f
+incdir+logic
+incdir+testbench
logic/decode_pkg.sv
logic/decode_if.sv
logic/instr_decoder.sv
logic/control_unit.sv
logic/register_file.sv
logic/operand_select.sv
logic/id_stage.sv
testbench/tb_id_stage.sv

// File: Makefile
TOP = tb_id_stage

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Something failed" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "Everything OK" sim.log; then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_id_tests.svh
task automatic reset_and_r0();
    int errs_before;
    errs_before = error_count;
    for (int r = 1; r < 32; r++)    // Leave something for the reset to clear
        drive_cycle(r_type_word(5'd0, 5'd0, 5'd1, 5'd0, 6'h21), 32'h0, 1'b0, 1'b1, 5'(r),
                    take_bits(32) | 32'h1);     // Never zero
    @(negedge i_clk);
    i_wr_en = 1'b0;
    i_rst   = 1'b1;
    @(negedge i_clk);
    i_rst   = 1'b0;
    for (int r = 0; r < 32; r++) begin
        present(r_type_word(5'(r), 5'(r), 5'd1, 5'd0, 6'h21), 32'h0);   // ADDU
        check_value("o_alu_src_a", o_alu_src_a, 32'h0);
        check_value("o_alu_src_b", o_alu_src_b, 32'h0);
    end
    drive_cycle(r_type_word(5'd0, 5'd0, 5'd1, 5'd0, 6'h21), 32'h0, 1'b0, 1'b1, 5'd0,
                take_bits(32));
    check_value("o_alu_src_a", o_alu_src_a, 32'h0);     // No write-through for r0
    present(r_type_word(5'd0, 5'd0, 5'd1, 5'd0, 6'h21), 32'h0);
    check_value("o_alu_src_a", o_alu_src_a, 32'h0);
    report_test("reset and register zero", errs_before);
endtask

task automatic write_and_readback();
    int          errs_before;
    logic [4:0]  rd;
    logic [4:0]  other;
    logic [31:0] data;
    errs_before = error_count;
    for (int r = 1; r < 32; r++) begin
        model_regs[r] = take_bits(32);
        drive_cycle(r_type_word(5'(r), 5'd0, 5'd1, 5'd0, 6'h21), 32'h0, 1'b0, 1'b1,
                    5'(r), model_regs[r]);
        check_value("o_alu_src_a", o_alu_src_a, model_regs[r]);
    end
    repeat (16) begin
        rd    = 5'(take_bits(5));
        other = 5'(take_bits(5));
        data  = take_bits(32);
        if (rd != 5'd0)
            model_regs[rd] = data;
        drive_cycle(r_type_word(rd, other, 5'd1, 5'd0, 6'h21), 32'h0, 1'b0, 1'b1, rd, data);
        check_value("o_alu_src_a", o_alu_src_a, model_regs[rd]);
        check_value("o_alu_src_b", o_alu_src_b, model_regs[other]);
        present(r_type_word(other, rd, 5'd1, 5'd0, 6'h21), 32'h0);
        check_value("o_alu_src_a", o_alu_src_a, model_regs[other]);
        check_value("o_alu_src_b", o_alu_src_b, model_regs[rd]);
    end
    report_test("register writes and write-through", errs_before);
endtask

task automatic r_alu_case(input logic [5:0] funct, input logic [4:0] shamt,
                          input logic is_shift, input alu_op_e exp_op);
    present(r_type_word(5'd5, 5'd9, 5'd12, shamt, funct), 32'h0);
    check_value("o_alu_op", 32'(o_alu_op), 32'(exp_op));
    check_value("o_alu_src_a", o_alu_src_a, is_shift ? 32'(shamt) : model_regs[5]);
    check_value("o_alu_src_b", o_alu_src_b, model_regs[9]);
    check_value("o_alu_dst", 32'(o_alu_dst), 32'(DST_RD));
    check_value("o_rd", 32'(o_rd), 32'd12);
    expect_flags(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
endtask

task automatic decode_r_type();
    int          errs_before;
    logic [31:0] pc;
    errs_before = error_count;
    r_alu_case(6'h21, 5'd0, 1'b0, OP_ADD);
    r_alu_case(6'h23, 5'd0, 1'b0, OP_SUB);
    r_alu_case(6'h24, 5'd0, 1'b0, OP_AND);
    r_alu_case(6'h25, 5'd0, 1'b0, OP_OR);
    r_alu_case(6'h26, 5'd0, 1'b0, OP_XOR);
    r_alu_case(6'h27, 5'd0, 1'b0, OP_NOR);
    r_alu_case(6'h2a, 5'd0, 1'b0, OP_SLT);
    r_alu_case(6'h00, 5'(take_bits(5)), 1'b1, OP_SLL);
    r_alu_case(6'h02, 5'(take_bits(5)), 1'b1, OP_SRL);
    r_alu_case(6'h03, 5'(take_bits(5)), 1'b1, OP_SRA);
    present(r_type_word(5'd5, 5'd0, 5'd0, 5'd0, 6'h08), 32'h0);     // JR
    check_value("o_flg_jmp_trg_reg", 32'(o_flg_jmp_trg_reg), 32'd1);
    check_value("o_rs", 32'(o_rs), 32'd5);
    expect_flags(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    pc = take_bits(32) & 32'hffff_fffc;
    present(r_type_word(5'd5, 5'd0, 5'd31, 5'd0, 6'h09), pc);       // JALR
    check_value("o_flg_jmp_trg_reg", 32'(o_flg_jmp_trg_reg), 32'd1);
    check_value("o_alu_src_a", o_alu_src_a, pc);
    check_value("o_alu_src_b", o_alu_src_b, 32'd4);
    check_value("o_alu_op", 32'(o_alu_op), 32'(OP_ADD));
    check_value("o_alu_dst", 32'(o_alu_dst), 32'(DST_RD));
    expect_flags(1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
    report_test("R-type decode", errs_before);
endtask

task automatic imm_case(input logic [5:0] opcode, input ext_mode_e mode,
                        input alu_op_e exp_op);
    logic [15:0] imm;
    logic [31:0] exp_ext;
    imm = 16'(take_bits(16));
    case (mode)
        EXT_ZERO:  exp_ext = {16'h0000, imm};
        EXT_UPPER: exp_ext = {imm, 16'h0000};
        default:   exp_ext = {{16{imm[15]}}, imm};
    endcase
    present(i_type_word(opcode, 5'd7, 5'd14, imm), 32'h0);
    check_value("o_ext_imm", o_ext_imm, exp_ext);
    check_value("o_alu_src_b", o_alu_src_b, exp_ext);
    check_value("o_alu_src_a", o_alu_src_a, model_regs[7]);
    check_value("o_alu_op", 32'(o_alu_op), 32'(exp_op));
    check_value("o_alu_dst", 32'(o_alu_dst), 32'(DST_RT));
    check_value("o_rt", 32'(o_rt), 32'd14);
    expect_flags(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
endtask

task automatic extend_immediates();
    int errs_before;
    errs_before = error_count;
    repeat (4) begin
        imm_case(6'h09, EXT_SIGN, OP_ADD);     // ADDIU
        imm_case(6'h0a, EXT_SIGN, OP_SLT);     // SLTI
        imm_case(6'h0c, EXT_ZERO, OP_AND);
        imm_case(6'h0d, EXT_ZERO, OP_OR);
        imm_case(6'h0e, EXT_ZERO, OP_XOR);
        imm_case(6'h0f, EXT_UPPER, OP_PASS_B); // LUI
    end
    report_test("immediate extension", errs_before);
endtask

task automatic mem_case(input logic [5:0] opcode, input logic is_store,
                        input mem_size_e exp_size, input logic exp_unsign);
    logic [15:0] imm;
    imm = 16'(take_bits(16));
    present(i_type_word(opcode, 5'd3, 5'd20, imm), 32'h0);
    check_value("o_flg_mem_size", 32'(o_flg_mem_size), 32'(exp_size));
    check_value("o_flg_unsign", 32'(o_flg_unsign), 32'(exp_unsign));
    check_value("o_flg_wb_src", 32'(o_flg_wb_src), 32'(!is_store));
    check_value("o_agu_base", o_agu_base, model_regs[3]);
    check_value("o_alu_src_b", o_alu_src_b, {{16{imm[15]}}, imm});
    check_value("o_alu_dst", 32'(o_alu_dst), 32'(DST_RT));
    expect_flags(1'b0, 1'b0, !is_store, is_store, 1'b1);
endtask

task automatic decode_memory_ops();
    int errs_before;
    errs_before = error_count;
    mem_case(6'h20, 1'b0, MEM_BYTE, 1'b0);     // LB
    mem_case(6'h21, 1'b0, MEM_HALF, 1'b0);
    mem_case(6'h23, 1'b0, MEM_WORD, 1'b0);
    mem_case(6'h24, 1'b0, MEM_BYTE, 1'b1);     // LBU
    mem_case(6'h25, 1'b0, MEM_HALF, 1'b1);
    mem_case(6'h28, 1'b1, MEM_BYTE, 1'b0);     // SB
    mem_case(6'h29, 1'b1, MEM_HALF, 1'b0);
    mem_case(6'h2b, 1'b1, MEM_WORD, 1'b0);
    report_test("memory instructions", errs_before);
endtask

task automatic bubble_case(input logic [31:0] instr, input logic hazard);
    drive_cycle(instr, 32'h0000_0100, hazard, 1'b0, 5'd0, 32'h0);
    expect_flags(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
endtask

task automatic control_flow_and_bubbles();
    int          errs_before;
    logic [31:0] pc;
    logic [25:0] target;
    errs_before = error_count;
    pc     = take_bits(32) & 32'hffff_fffc;
    target = 26'(take_bits(26));
    present(i_type_word(6'h04, 5'd2, 5'd3, 16'h0010), pc);          // BEQ
    check_value("o_flg_equal", 32'(o_flg_equal), 32'd1);
    check_value("o_agu_base", o_agu_base, pc);
    expect_flags(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    present(i_type_word(6'h05, 5'd2, 5'd3, 16'hfff0), pc);          // BNE
    check_value("o_flg_equal", 32'(o_flg_equal), 32'd0);
    check_value("o_agu_base", o_agu_base, pc);
    expect_flags(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    present(j_type_word(6'h02, target), pc);                        // J
    check_value("o_addr_offset", 32'(o_addr_offset), 32'(target));
    check_value("o_agu_base", o_agu_base, pc);
    check_value("o_flg_jmp_trg_reg", 32'(o_flg_jmp_trg_reg), 32'd0);
    expect_flags(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    present(j_type_word(6'h03, target), pc);                        // JAL
    check_value("o_addr_offset", 32'(o_addr_offset), 32'(target));
    check_value("o_alu_dst", 32'(o_alu_dst), 32'(DST_RA));
    check_value("o_alu_src_a", o_alu_src_a, pc);
    check_value("o_alu_src_b", o_alu_src_b, 32'd4);
    expect_flags(1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
    // Hazard masks every class
    bubble_case(r_type_word(5'd1, 5'd2, 5'd3, 5'd0, 6'h21), 1'b1);
    bubble_case(i_type_word(6'h23, 5'd1, 5'd2, 16'h0004), 1'b1);
    bubble_case(i_type_word(6'h2b, 5'd1, 5'd2, 16'h0008), 1'b1);
    bubble_case(i_type_word(6'h04, 5'd1, 5'd2, 16'h0002), 1'b1);
    bubble_case(j_type_word(6'h02, target), 1'b1);
    bubble_case(j_type_word(6'h03, target), 1'b1);
    bubble_case(r_type_word(5'd4, 5'd0, 5'd31, 5'd0, 6'h09), 1'b1);
    // Encodings outside the subset
    bubble_case(i_type_word(6'h08, 5'd1, 5'd2, 16'h0001), 1'b0);
    bubble_case(i_type_word(6'h01, 5'd1, 5'd0, 16'h0001), 1'b0);
    bubble_case(r_type_word(5'd1, 5'd2, 5'd3, 5'd0, 6'h20), 1'b0);
    bubble_case(32'hffff_ffff, 1'b0);
    report_test("control flow and bubbles", errs_before);
endtask

// File: testbench/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage import decode_pkg::*; ();

    localparam int TEST_CYCLES    = 200;    // Rough length of the whole sequence
    localparam int TIMEOUT_CYCLES = 10 * TEST_CYCLES;

    logic        i_clk;
    logic        i_rst;
    logic        i_hazard_detected;
    logic [4:0]  i_rd_sel;
    logic        i_wr_en;
    logic [31:0] i_wr_data;
    logic [31:0] i_pc;
    logic [31:0] i_instruction;

    logic [31:0] o_alu_src_a;
    logic [31:0] o_alu_src_b;
    logic [31:0] o_agu_base;
    logic [31:0] o_ext_imm;
    logic [25:0] o_addr_offset;
    alu_op_e     o_alu_op;
    alu_dst_e    o_alu_dst;
    logic [4:0]  o_rs;
    logic [4:0]  o_rt;
    logic [4:0]  o_rd;
    logic        o_flg_jump;
    logic        o_flg_branch;
    logic        o_flg_jmp_trg_reg;
    logic        o_flg_reg_wr_en;
    logic        o_flg_mem_wr_en;
    logic        o_flg_mem_op;
    logic        o_flg_wb_src;
    mem_size_e   o_flg_mem_size;
    logic        o_flg_unsign;
    logic        o_flg_equal;

    logic [31:0] model_regs [32];   // Expected register contents
    logic [31:0] lfsr_state;
    int          error_count;
    int          check_count;
    int          cycle_count = 0;

    id_stage dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing the tests", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] r_type_word(input logic [4:0] rs, rt, rd, shamt,
                                                input logic [5:0] funct);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [5:0] opcode,
                                                input logic [4:0] rs, rt,
                                                input logic [15:0] imm);
        return {opcode, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_type_word(input logic [5:0] opcode,
                                                input logic [25:0] target);
        return {opcode, target};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: got %h, expected %h (instruction %h)",
                     name, actual, expected, i_instruction);
        end
    endtask

    task automatic drive_cycle(input logic [31:0] instr, input logic [31:0] pc,
                               input logic hazard, input logic wr_en,
                               input logic [4:0] rd_sel, input logic [31:0] wr_data);
        @(negedge i_clk);
        i_instruction     = instr;
        i_pc              = pc;
        i_hazard_detected = hazard;
        i_wr_en           = wr_en;
        i_rd_sel          = rd_sel;
        i_wr_data         = wr_data;
        #3;     // Sample just ahead of the rising edge
    endtask

    task automatic present(input logic [31:0] instr, input logic [31:0] pc);
        drive_cycle(instr, pc, 1'b0, 1'b0, 5'd0, 32'h0);
    endtask

    task automatic expect_flags(input logic jump, branch, reg_wr, mem_wr, mem_op);
        check_value("o_flg_jump", 32'(o_flg_jump), 32'(jump));
        check_value("o_flg_branch", 32'(o_flg_branch), 32'(branch));
        check_value("o_flg_reg_wr_en", 32'(o_flg_reg_wr_en), 32'(reg_wr));
        check_value("o_flg_mem_wr_en", 32'(o_flg_mem_wr_en), 32'(mem_wr));
        check_value("o_flg_mem_op", 32'(o_flg_mem_op), 32'(mem_op));
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("Test %s finished, %0d mismatches", name, error_count - errs_before);
    endtask

`include "tb_id_tests.svh"

    initial begin
        i_rst             = 1'b1;
        i_hazard_detected = 1'b0;
        i_rd_sel          = 5'd0;
        i_wr_en           = 1'b0;
        i_wr_data         = 32'h0;
        i_pc              = 32'h0;
        i_instruction     = 32'h0;
        lfsr_state        = 32'd67701;
        error_count       = 0;
        check_count       = 0;
        for (int r = 0; r < 32; r++)
            model_regs[r] = 32'h0;
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;

        reset_and_r0();
        write_and_readback();
        decode_r_type();
        extend_immediates();
        decode_memory_ops();
        control_flow_and_bubbles();

        $display("Checks run: %0d, mismatches: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: logic/id_stage.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module id_stage import decode_pkg::*; (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_hazard_detected,

    // Write-back port
    input  logic [`REG_SEL_WIDTH-1:0] i_rd_sel,
    input  logic                      i_wr_en,
    input  logic [`DATA_WIDTH-1:0]    i_wr_data,

    input  logic [`DATA_WIDTH-1:0]    i_pc,
    input  logic [`DATA_WIDTH-1:0]    i_instruction,

    output logic [`DATA_WIDTH-1:0]    o_alu_src_a,
    output logic [`DATA_WIDTH-1:0]    o_alu_src_b,
    output logic [`DATA_WIDTH-1:0]    o_agu_base,
    output logic [`DATA_WIDTH-1:0]    o_ext_imm,
    output logic [25:0]               o_addr_offset,
    output alu_op_e                   o_alu_op,
    output alu_dst_e                  o_alu_dst,
    output logic [`REG_SEL_WIDTH-1:0] o_rs,
    output logic [`REG_SEL_WIDTH-1:0] o_rt,
    output logic [`REG_SEL_WIDTH-1:0] o_rd,

    output logic                      o_flg_jump,
    output logic                      o_flg_branch,
    output logic                      o_flg_jmp_trg_reg,
    output logic                      o_flg_reg_wr_en,
    output logic                      o_flg_mem_wr_en,
    output logic                      o_flg_mem_op,
    output logic                      o_flg_wb_src,
    output mem_size_e                 o_flg_mem_size,
    output logic                      o_flg_unsign,
    output logic                      o_flg_equal
);

    logic [`REG_SEL_WIDTH-1:0] rs_sel;
    logic [`REG_SEL_WIDTH-1:0] rt_sel;
    logic [`DATA_WIDTH-1:0]    rs_data;
    logic [`DATA_WIDTH-1:0]    rt_data;
    ext_mode_e                 ext_mode;
    src_a_sel_e                src_a_sel;
    src_b_sel_e                src_b_sel;
    logic                      agu_from_pc;

    decode_if fields (.i_clk(i_clk));

    assign rs_sel        = fields.rs;
    assign rt_sel        = fields.rt;
    assign o_rs          = rs_sel;
    assign o_rt          = rt_sel;
    assign o_rd          = fields.rd;
    assign o_addr_offset = fields.target26;

    instr_decoder u_decoder (
        .i_instruction (i_instruction),
        .o_fields      (fields)
    );

    control_unit u_ctrl (
        .i_fields          (fields),
        .i_hazard_detected (i_hazard_detected),
        .o_alu_op          (o_alu_op),
        .o_alu_dst         (o_alu_dst),
        .o_src_a_sel       (src_a_sel),
        .o_src_b_sel       (src_b_sel),
        .o_ext_mode        (ext_mode),
        .o_agu_from_pc     (agu_from_pc),
        .o_flg_jump        (o_flg_jump),
        .o_flg_branch      (o_flg_branch),
        .o_flg_jmp_trg_reg (o_flg_jmp_trg_reg),
        .o_flg_reg_wr_en   (o_flg_reg_wr_en),
        .o_flg_mem_wr_en   (o_flg_mem_wr_en),
        .o_flg_mem_op      (o_flg_mem_op),
        .o_flg_wb_src      (o_flg_wb_src),
        .o_flg_mem_size    (o_flg_mem_size),
        .o_flg_unsign      (o_flg_unsign),
        .o_flg_equal       (o_flg_equal)
    );

    register_file u_regs (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_rs_sel  (rs_sel),
        .i_rt_sel  (rt_sel),
        .i_rd_sel  (i_rd_sel),
        .i_wr_en   (i_wr_en),
        .i_wr_data (i_wr_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    operand_select u_opnd (
        .i_fields      (fields),
        .i_pc          (i_pc),
        .i_rs_data     (rs_data),
        .i_rt_data     (rt_data),
        .i_src_a_sel   (src_a_sel),
        .i_src_b_sel   (src_b_sel),
        .i_ext_mode    (ext_mode),
        .i_agu_from_pc (agu_from_pc),
        .o_alu_src_a   (o_alu_src_a),
        .o_alu_src_b   (o_alu_src_b),
        .o_agu_base    (o_agu_base),
        .o_ext_imm     (o_ext_imm)
    );

endmodule

// File: logic/operand_select.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module operand_select import decode_pkg::*; (
    decode_if.opnd                  i_fields,
    input  logic [`DATA_WIDTH-1:0]  i_pc,
    input  logic [`DATA_WIDTH-1:0]  i_rs_data,
    input  logic [`DATA_WIDTH-1:0]  i_rt_data,
    input  src_a_sel_e              i_src_a_sel,
    input  src_b_sel_e              i_src_b_sel,
    input  ext_mode_e               i_ext_mode,
    input  logic                    i_agu_from_pc,

    output logic [`DATA_WIDTH-1:0]  o_alu_src_a,
    output logic [`DATA_WIDTH-1:0]  o_alu_src_b,
    output logic [`DATA_WIDTH-1:0]  o_agu_base,
    output logic [`DATA_WIDTH-1:0]  o_ext_imm
);

    always_comb begin
        case (i_ext_mode)
            EXT_ZERO:  o_ext_imm = {{(`DATA_WIDTH-16){1'b0}}, i_fields.imm16};
            EXT_UPPER: o_ext_imm = {i_fields.imm16, {(`DATA_WIDTH-16){1'b0}}};    // LUI
            default:   o_ext_imm = {{(`DATA_WIDTH-16){i_fields.imm16[15]}}, i_fields.imm16};
        endcase
    end

    always_comb begin
        case (i_src_a_sel)
            A_SHAMT: o_alu_src_a = {{(`DATA_WIDTH-5){1'b0}}, i_fields.shamt};
            A_PC:    o_alu_src_a = i_pc;
            default: o_alu_src_a = i_rs_data;
        endcase
    end

    always_comb begin
        case (i_src_b_sel)
            B_IMM:   o_alu_src_b = o_ext_imm;
            B_FOUR:  o_alu_src_b = `DATA_WIDTH'(4);   // Link offset
            default: o_alu_src_b = i_rt_data;
        endcase
    end

    assign o_agu_base = i_agu_from_pc ? i_pc : i_rs_data;

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module register_file (
    input  logic                      i_clk,
    input  logic                      i_rst,

    input  logic [`REG_SEL_WIDTH-1:0] i_rs_sel,
    input  logic [`REG_SEL_WIDTH-1:0] i_rt_sel,

    input  logic [`REG_SEL_WIDTH-1:0] i_rd_sel,
    input  logic                      i_wr_en,
    input  logic [`DATA_WIDTH-1:0]    i_wr_data,

    output logic [`DATA_WIDTH-1:0]    o_rs_data,
    output logic [`DATA_WIDTH-1:0]    o_rt_data
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
    logic                   wr_live;
    logic                   rs_bypass;
    logic                   rt_bypass;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int k = 0; k < `REG_COUNT; k++)
                regs[k] <= '0;
        end else if (wr_live) begin
            regs[i_rd_sel] <= i_wr_data;
        end
    end

    assign wr_live = i_wr_en && (i_rd_sel != '0);   // r0 is hardwired

    // Same-cycle write is seen by the reader
    assign rs_bypass = wr_live && (i_rd_sel == i_rs_sel);
    assign rt_bypass = wr_live && (i_rd_sel == i_rt_sel);

    assign o_rs_data = (i_rs_sel == '0) ? '0 : rs_bypass ? i_wr_data : regs[i_rs_sel];
    assign o_rt_data = (i_rt_sel == '0) ? '0 : rt_bypass ? i_wr_data : regs[i_rt_sel];

    a_r0_zero: assert property (
        @(posedge i_clk) disable iff (i_rst) regs[0] == '0
    );

endmodule

// File: logic/control_unit.sv
`timescale 1ns/1ps

module control_unit import decode_pkg::*; (
    decode_if.ctrl      i_fields,
    input  logic        i_hazard_detected,

    output alu_op_e     o_alu_op,
    output alu_dst_e    o_alu_dst,
    output src_a_sel_e  o_src_a_sel,
    output src_b_sel_e  o_src_b_sel,
    output ext_mode_e   o_ext_mode,
    output logic        o_agu_from_pc,

    output logic        o_flg_jump,
    output logic        o_flg_branch,
    output logic        o_flg_jmp_trg_reg,
    output logic        o_flg_reg_wr_en,
    output logic        o_flg_mem_wr_en,
    output logic        o_flg_mem_op,
    output logic        o_flg_wb_src,
    output mem_size_e   o_flg_mem_size,
    output logic        o_flg_unsign,
    output logic        o_flg_equal
);

    logic bubble;
    logic jump;
    logic branch;
    logic reg_wr_en;
    logic mem_wr_en;
    logic mem_op;

    assign o_alu_op = i_fields.funct_op;   // Decoder already resolved the operation

    always_comb begin
        o_alu_dst         = DST_RD;
        o_src_a_sel       = A_RS;
        o_src_b_sel       = B_RT;
        o_ext_mode        = EXT_SIGN;
        o_agu_from_pc     = 1'b0;
        o_flg_jmp_trg_reg = 1'b0;
        o_flg_wb_src      = 1'b0;
        o_flg_mem_size    = MEM_WORD;
        o_flg_unsign      = 1'b0;
        o_flg_equal       = 1'b0;
        jump              = 1'b0;
        branch            = 1'b0;
        reg_wr_en         = 1'b0;
        mem_wr_en         = 1'b0;
        mem_op            = 1'b0;
        case (i_fields.instr_class)
            ALU_REG: reg_wr_en = 1'b1;
            SHIFT_IMM: begin
                o_src_a_sel = A_SHAMT;
                reg_wr_en   = 1'b1;
            end
            JUMP_REG: begin
                jump              = 1'b1;
                o_flg_jmp_trg_reg = 1'b1;   // Target taken from rs
            end
            JUMP_REG_LINK: begin
                jump              = 1'b1;
                o_flg_jmp_trg_reg = 1'b1;
                o_src_a_sel       = A_PC;   // Return address PC + 4
                o_src_b_sel       = B_FOUR;
                reg_wr_en         = 1'b1;
            end
            ALU_IMM_SIGNED, ALU_IMM_UNSIGNED, LOAD_UPPER: begin
                o_alu_dst   = DST_RT;
                o_src_b_sel = B_IMM;
                reg_wr_en   = 1'b1;
                if (i_fields.instr_class == ALU_IMM_UNSIGNED)
                    o_ext_mode = EXT_ZERO;
                else if (i_fields.instr_class == LOAD_UPPER)
                    o_ext_mode = EXT_UPPER;
            end
            BRANCH: begin
                branch        = 1'b1;
                o_agu_from_pc = 1'b1;
                o_flg_equal   = ~i_fields.opcode[0];    // BEQ 04, BNE 05
            end
            LOAD: begin
                o_alu_dst      = DST_RT;
                o_src_b_sel    = B_IMM;
                mem_op         = 1'b1;
                o_flg_wb_src   = 1'b1;
                reg_wr_en      = 1'b1;
                o_flg_mem_size = mem_size_e'(i_fields.opcode[1:0]);
                o_flg_unsign   = i_fields.opcode[2];    // LBU, LHU
            end
            STORE: begin
                o_alu_dst      = DST_RT;
                o_src_b_sel    = B_IMM;
                mem_op         = 1'b1;
                mem_wr_en      = 1'b1;
                o_flg_mem_size = mem_size_e'(i_fields.opcode[1:0]);
            end
            JUMP: begin
                jump          = 1'b1;
                o_agu_from_pc = 1'b1;
            end
            JUMP_LINK: begin
                jump          = 1'b1;
                o_agu_from_pc = 1'b1;
                o_alu_dst     = DST_RA;
                o_src_a_sel   = A_PC;
                o_src_b_sel   = B_FOUR;
                reg_wr_en     = 1'b1;
            end
            default: ;
        endcase
    end

    // Hazard or unsupported encoding turns the slot into a bubble
    assign bubble = i_hazard_detected || (i_fields.instr_class == INVALID);

    assign o_flg_jump      = jump      & ~bubble;
    assign o_flg_branch    = branch    & ~bubble;
    assign o_flg_reg_wr_en = reg_wr_en & ~bubble;
    assign o_flg_mem_wr_en = mem_wr_en & ~bubble;
    assign o_flg_mem_op    = mem_op    & ~bubble;

    a_single_writer: assert property (
        @(posedge i_fields.i_clk) !(o_flg_reg_wr_en && o_flg_mem_wr_en)
    );

    a_hazard_bubble: assert property (
        @(posedge i_fields.i_clk)
        i_hazard_detected |-> !(o_flg_reg_wr_en || o_flg_mem_wr_en || o_flg_mem_op ||
                                o_flg_jump || o_flg_branch)
    );

endmodule

// File: logic/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import decode_pkg::*; (
    input  instr_word_u     i_instruction,
    decode_if.source        o_fields
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = i_instruction.r.opcode;
    assign funct  = i_instruction.r.funct;

    assign o_fields.opcode   = opcode;
    assign o_fields.rs       = i_instruction.r.rs;
    assign o_fields.rt       = i_instruction.r.rt;
    assign o_fields.rd       = i_instruction.r.rd;
    assign o_fields.shamt    = i_instruction.r.shamt;
    assign o_fields.imm16    = i_instruction.i.imm;
    assign o_fields.target26 = i_instruction.j.target;

    always_comb begin
        o_fields.instr_class = INVALID;
        o_fields.funct_op    = OP_ADD;
        case (opcode)
            6'h00: begin                            // SPECIAL, look at funct
                case (funct)
                    6'h00: begin o_fields.instr_class = SHIFT_IMM; o_fields.funct_op = OP_SLL; end
                    6'h02: begin o_fields.instr_class = SHIFT_IMM; o_fields.funct_op = OP_SRL; end
                    6'h03: begin o_fields.instr_class = SHIFT_IMM; o_fields.funct_op = OP_SRA; end
                    6'h08: o_fields.instr_class = JUMP_REG;         // JR
                    6'h09: o_fields.instr_class = JUMP_REG_LINK;    // JALR
                    6'h21: begin o_fields.instr_class = ALU_REG; o_fields.funct_op = OP_ADD; end
                    6'h23: begin o_fields.instr_class = ALU_REG; o_fields.funct_op = OP_SUB; end
                    6'h24: begin o_fields.instr_class = ALU_REG; o_fields.funct_op = OP_AND; end
                    6'h25: begin o_fields.instr_class = ALU_REG; o_fields.funct_op = OP_OR;  end
                    6'h26: begin o_fields.instr_class = ALU_REG; o_fields.funct_op = OP_XOR; end
                    6'h27: begin o_fields.instr_class = ALU_REG; o_fields.funct_op = OP_NOR; end
                    6'h2a: begin o_fields.instr_class = ALU_REG; o_fields.funct_op = OP_SLT; end
                    default: o_fields.instr_class = INVALID;
                endcase
            end
            6'h02: o_fields.instr_class = JUMP;         // J
            6'h03: o_fields.instr_class = JUMP_LINK;    // JAL
            6'h04, 6'h05: begin                         // BEQ, BNE compare by subtract
                o_fields.instr_class = BRANCH;
                o_fields.funct_op    = OP_SUB;
            end
            6'h09: o_fields.instr_class = ALU_IMM_SIGNED;   // ADDIU
            6'h0a: begin                                    // SLTI
                o_fields.instr_class = ALU_IMM_SIGNED;
                o_fields.funct_op    = OP_SLT;
            end
            6'h0c: begin o_fields.instr_class = ALU_IMM_UNSIGNED; o_fields.funct_op = OP_AND; end
            6'h0d: begin o_fields.instr_class = ALU_IMM_UNSIGNED; o_fields.funct_op = OP_OR;  end
            6'h0e: begin o_fields.instr_class = ALU_IMM_UNSIGNED; o_fields.funct_op = OP_XOR; end
            6'h0f: begin                                    // LUI
                o_fields.instr_class = LOAD_UPPER;
                o_fields.funct_op    = OP_PASS_B;
            end
            6'h20, 6'h21, 6'h23, 6'h24, 6'h25: o_fields.instr_class = LOAD;
            6'h28, 6'h29, 6'h2b: o_fields.instr_class = STORE;
            default: o_fields.instr_class = INVALID;
        endcase
    end

    // Control unit relies on INVALID to bubble anything outside the subset
    a_unknown_opcode_invalid: assert property (
        @(posedge o_fields.i_clk)
        !(opcode inside {6'h00, 6'h02, 6'h03, 6'h04, 6'h05, 6'h09, 6'h0a, 6'h0c, 6'h0d,
                         6'h0e, 6'h0f, 6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29,
                         6'h2b})
        |-> o_fields.instr_class == INVALID
    );

endmodule

// File: logic/decode_if.sv
`timescale 1ns/1ps
`include "decode_config.svh"

interface decode_if import decode_pkg::*; (
    input logic i_clk
);

    instr_class_e              instr_class;
    alu_op_e                   funct_op;
    logic [5:0]                opcode;      // Size, sign and branch sense live here
    logic [`REG_SEL_WIDTH-1:0] rs;
    logic [`REG_SEL_WIDTH-1:0] rt;
    logic [`REG_SEL_WIDTH-1:0] rd;
    logic [4:0]                shamt;
    logic [15:0]               imm16;
    logic [25:0]               target26;

    modport source (
        input  i_clk,
        output instr_class, funct_op, opcode, rs, rt, rd, shamt, imm16, target26
    );

    modport ctrl (
        input i_clk,
        input instr_class, funct_op, opcode
    );

    modport opnd (
        input shamt, imm16
    );

endinterface

// File: logic/decode_pkg.sv
package decode_pkg;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_fields_t;

    // Same fetched word, three field layouts
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } instr_word_u;

    typedef enum logic [4:0] {
        ALU_REG,
        SHIFT_IMM,
        JUMP_REG,
        JUMP_REG_LINK,
        ALU_IMM_SIGNED,
        ALU_IMM_UNSIGNED,
        LOAD_UPPER,
        BRANCH,
        LOAD,
        STORE,
        JUMP,
        JUMP_LINK,
        INVALID
    } instr_class_e;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLT,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {EXT_SIGN, EXT_ZERO, EXT_UPPER} ext_mode_e;
    typedef enum logic [1:0] {A_RS, A_SHAMT, A_PC} src_a_sel_e;
    typedef enum logic [1:0] {B_RT, B_IMM, B_FOUR} src_b_sel_e;

    // Matches opcode[1:0] of the load/store encodings
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b11
    } mem_size_e;

    typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} alu_dst_e;

endpackage

// File: logic/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Datapath width for registers, PC and operands
`define DATA_WIDTH 32

// Architectural register file
`define REG_COUNT 32
`define REG_SEL_WIDTH 5

`endif
